//--- Bender.yml
package:
  name: avr_io_peripherals

sources:
  - design/avr_io_pkg.sv
  - design/io_bus_if.sv
  - design/parallel_port.sv
  - design/usart_tx_regs.sv
  - design/tx_fifo.sv
  - design/usart_tx_shifter.sv
  - design/io_read_mux.sv
  - design/peripherals.sv
  - target: simulation
    files:
      - verification/tb_peripherals.sv

//--- design/avr_io_pkg.sv
package avr_io_pkg;

   // ==================================================
   // I/O bus types
   // ==================================================

   typedef logic [5:0] io_adr_t;
   typedef logic [7:0] io_data_t;

   // Read return of one slave
   typedef struct packed {
      logic     out_en;
      io_data_t data;
   } io_rd_t;

   // ==================================================
   // Register addresses
   // ==================================================

   // Parallel ports
   localparam io_adr_t PORTA_ADR = 6'h1B;
   localparam io_adr_t DDRA_ADR  = 6'h1A;
   localparam io_adr_t PINA_ADR  = 6'h19;
   localparam io_adr_t PORTB_ADR = 6'h18;
   localparam io_adr_t DDRB_ADR  = 6'h17;
   localparam io_adr_t PINB_ADR  = 6'h16;

   // USART
   localparam io_adr_t UDR_ADR   = 6'h0C;
   localparam io_adr_t UCSRA_ADR = 6'h0B;
   localparam io_adr_t UCSRB_ADR = 6'h0A;
   localparam io_adr_t UBRR_ADR  = 6'h09;

   // UCSRA bits
   localparam int UDRE_BIT  = 5;
   localparam int TXC_BIT   = 6;

   // UCSRB bits
   localparam int TXEN_BIT  = 3;
   localparam int UDRIE_BIT = 5;
   localparam int TXCIE_BIT = 6;

   // Clock ticks per baud unit
   localparam int BAUD_OVERSAMPLE = 16;

endpackage

//--- design/io_bus_if.sv
interface io_bus_if
   import avr_io_pkg::*;
();

   io_adr_t  adr;
   logic     iore;
   logic     iowe;
   io_data_t dbus_in;

   // Core side
   modport master (
      output adr, iore, iowe, dbus_in
   );

   // Peripheral side
   modport slave (
      input adr, iore, iowe, dbus_in
   );

endinterface

//--- design/io_read_mux.sv
module io_read_mux
   import avr_io_pkg::*;
#(
   parameter int num_slaves = 3
) (
   input  io_rd_t   slv_rd [num_slaves],
   output logic     out_en,
   output io_data_t dbus_out
);

   logic     en_c   [num_slaves+1];
   io_data_t data_c [num_slaves+1];

   assign en_c[0]   = 1'b0;
   assign data_c[0] = '0;

   // Later stages override earlier ones
   for (genvar i = 0; i < num_slaves; i++) begin : chain
      assign en_c[i+1]   = slv_rd[i].out_en | en_c[i];
      assign data_c[i+1] = slv_rd[i].out_en ? slv_rd[i].data : data_c[i];
   end

   assign out_en   = en_c[num_slaves];
   assign dbus_out = data_c[num_slaves];

endmodule

//--- design/parallel_port.sv
module parallel_port
   import avr_io_pkg::*;
#(
   parameter io_adr_t portx_adr = PORTA_ADR,
   parameter io_adr_t ddrx_adr  = DDRA_ADR,
   parameter io_adr_t pinx_adr  = PINA_ADR
) (
   input  logic     cp2,
   input  logic     rst_n,
   io_bus_if.slave  bus,
   output io_rd_t   rd,
   output io_data_t portx,
   output io_data_t ddrx,
   input  io_data_t pinx
);

   io_data_t pin_meta;
   io_data_t pin_sync;

   // PORT and DDR registers
   always_ff @(posedge cp2 or negedge rst_n) begin
      if (!rst_n) begin
         portx <= '0;
         ddrx  <= '0;
      end else if (bus.iowe) begin
         if (bus.adr == portx_adr) begin
            portx <= bus.dbus_in;
         end
         if (bus.adr == ddrx_adr) begin
            ddrx <= bus.dbus_in;
         end
      end
   end

   // Two-stage synchronizer on the pins
   always_ff @(posedge cp2 or negedge rst_n) begin
      if (!rst_n) begin
         pin_meta <= '0;
         pin_sync <= '0;
      end else begin
         pin_meta <= pinx;
         pin_sync <= pin_meta;
      end
   end

   // Read decode, PIN is read only
   always_comb begin
      rd.out_en = 1'b0;
      rd.data   = '0;
      if (bus.iore) begin
         case (bus.adr)
            portx_adr: begin
               rd.out_en = 1'b1;
               rd.data   = portx;
            end
            ddrx_adr: begin
               rd.out_en = 1'b1;
               rd.data   = ddrx;
            end
            pinx_adr: begin
               rd.out_en = 1'b1;
               rd.data   = pin_sync;
            end
            default: ;
         endcase
      end
   end

endmodule

//--- design/peripherals.sv
module peripherals
   import avr_io_pkg::*;
#(
   parameter int tx_fifo_depth = 2
) (
   input  logic     cp2,
   input  logic     rst_n,
   // I/O slave bus
   input  io_adr_t  adr,
   input  logic     iore,
   input  logic     iowe,
   input  io_data_t dbus_in,
   output io_data_t dbus_out,
   output logic     out_en,
   // Port A
   output io_data_t porta_portx,
   output io_data_t porta_ddrx,
   input  io_data_t porta_pinx,
   // Port B
   output io_data_t portb_portx,
   output io_data_t portb_ddrx,
   input  io_data_t portb_pinx,
   // USART
   output logic     txd,
   output logic     udre_irq,
   output logic     txc_irq,
   input  logic     txc_irq_ack
);

   io_bus_if bus_if ();

   io_rd_t   slv_rd [3];
   logic     tx_valid;
   io_data_t tx_data;
   logic     fifo_in_ready;
   logic     fifo_out_valid;
   io_data_t fifo_out_data;
   logic     fifo_empty;
   logic     shift_ready;
   logic     frame_done;
   logic     txen;
   io_data_t ubrr;

   assign bus_if.adr     = adr;
   assign bus_if.iore    = iore;
   assign bus_if.iowe    = iowe;
   assign bus_if.dbus_in = dbus_in;

   // ==================================================
   // Parallel ports
   // ==================================================

   parallel_port #(
      .portx_adr (PORTA_ADR),
      .ddrx_adr  (DDRA_ADR),
      .pinx_adr  (PINA_ADR)
   ) port_a_i (
      .cp2   (cp2),
      .rst_n (rst_n),
      .bus   (bus_if.slave),
      .rd    (slv_rd[0]),
      .portx (porta_portx),
      .ddrx  (porta_ddrx),
      .pinx  (porta_pinx)
   );

   parallel_port #(
      .portx_adr (PORTB_ADR),
      .ddrx_adr  (DDRB_ADR),
      .pinx_adr  (PINB_ADR)
   ) port_b_i (
      .cp2   (cp2),
      .rst_n (rst_n),
      .bus   (bus_if.slave),
      .rd    (slv_rd[1]),
      .portx (portb_portx),
      .ddrx  (portb_ddrx),
      .pinx  (portb_pinx)
   );

   // ==================================================
   // USART transmitter
   // ==================================================

   usart_tx_regs tx_regs_i (
      .cp2         (cp2),
      .rst_n       (rst_n),
      .bus         (bus_if.slave),
      .rd          (slv_rd[2]),
      .tx_valid    (tx_valid),
      .tx_data     (tx_data),
      .fifo_ready  (fifo_in_ready),
      .frame_done  (frame_done),
      .fifo_empty  (fifo_empty),
      .txen        (txen),
      .ubrr        (ubrr),
      .udre_irq    (udre_irq),
      .txc_irq     (txc_irq),
      .txc_irq_ack (txc_irq_ack)
   );

   tx_fifo #(
      .payload_t (io_data_t),
      .depth     (tx_fifo_depth)
   ) tx_fifo_i (
      .cp2       (cp2),
      .rst_n     (rst_n),
      .in_valid  (tx_valid),
      .in_ready  (fifo_in_ready),
      .in_data   (tx_data),
      .out_valid (fifo_out_valid),
      .out_ready (shift_ready),
      .out_data  (fifo_out_data),
      .empty     (fifo_empty)
   );

   usart_tx_shifter tx_shifter_i (
      .cp2        (cp2),
      .rst_n      (rst_n),
      .in_valid   (fifo_out_valid),
      .in_ready   (shift_ready),
      .in_data    (fifo_out_data),
      .txen       (txen),
      .ubrr       (ubrr),
      .txd        (txd),
      .frame_done (frame_done)
   );

   // Read data merge, USART has top priority
   io_read_mux #(
      .num_slaves (3)
   ) read_mux_i (
      .slv_rd   (slv_rd),
      .out_en   (out_en),
      .dbus_out (dbus_out)
   );

endmodule

//--- design/tx_fifo.sv
module tx_fifo
   import avr_io_pkg::*;
#(
   parameter type payload_t = io_data_t,
   parameter int  depth     = 2
) (
   input  logic     cp2,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data,
   output logic     empty
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t           mem [depth];
   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;
   logic [cnt_w-1:0]   count;
   logic               push;
   logic               pop;

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   assign in_ready  = (count != cnt_w'(depth));
   assign out_valid = (count != '0);
   assign empty     = (count == '0);
   assign out_data  = mem[rd_ptr];

   // Storage
   always_ff @(posedge cp2) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // Pointers wrap at depth
   always_ff @(posedge cp2 or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- design/usart_tx_regs.sv
module usart_tx_regs
   import avr_io_pkg::*;
(
   input  logic     cp2,
   input  logic     rst_n,
   io_bus_if.slave  bus,
   output io_rd_t   rd,
   output logic     tx_valid,
   output io_data_t tx_data,
   input  logic     fifo_ready,
   input  logic     frame_done,
   input  logic     fifo_empty,
   output logic     txen,
   output io_data_t ubrr,
   output logic     udre_irq,
   output logic     txc_irq,
   input  logic     txc_irq_ack
);

   io_data_t ucsrb;
   io_data_t ucsra_val;
   logic     txc;
   logic     udr_wr;
   logic     ucsra_wr;

   assign udr_wr   = bus.iowe && (bus.adr == UDR_ADR);
   assign ucsra_wr = bus.iowe && (bus.adr == UCSRA_ADR);

   // ==================================================
   // Control and baud registers
   // ==================================================

   always_ff @(posedge cp2 or negedge rst_n) begin
      if (!rst_n) begin
         ucsrb <= '0;
         ubrr  <= '0;
      end else if (bus.iowe) begin
         if (bus.adr == UCSRB_ADR) begin
            ucsrb <= bus.dbus_in;
         end
         if (bus.adr == UBRR_ADR) begin
            ubrr <= bus.dbus_in;
         end
      end
   end

   assign txen = ucsrb[TXEN_BIT];

   // UDR write becomes a one-cycle stream beat
   always_ff @(posedge cp2 or negedge rst_n) begin
      if (!rst_n) begin
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= udr_wr;
      end
   end

   always_ff @(posedge cp2) begin
      if (udr_wr) begin
         tx_data <= bus.dbus_in;
      end
   end

   // TXC flag, set wins over clear
   always_ff @(posedge cp2 or negedge rst_n) begin
      if (!rst_n) begin
         txc <= 1'b0;
      end else if (frame_done && fifo_empty) begin
         txc <= 1'b1;
      end else if (txc_irq_ack || (ucsra_wr && bus.dbus_in[TXC_BIT])) begin
         txc <= 1'b0;
      end
   end

   // ==================================================
   // Status and read back
   // ==================================================

   always_comb begin
      ucsra_val           = '0;
      ucsra_val[UDRE_BIT] = fifo_ready;
      ucsra_val[TXC_BIT]  = txc;
   end

   always_comb begin
      rd.out_en = 1'b0;
      rd.data   = '0;
      if (bus.iore) begin
         case (bus.adr)
            // No receiver, UDR reads as zero
            UDR_ADR:   rd.out_en = 1'b1;
            UCSRA_ADR: begin
               rd.out_en = 1'b1;
               rd.data   = ucsra_val;
            end
            UCSRB_ADR: begin
               rd.out_en = 1'b1;
               rd.data   = ucsrb;
            end
            UBRR_ADR: begin
               rd.out_en = 1'b1;
               rd.data   = ubrr;
            end
            default: ;
         endcase
      end
   end

   assign udre_irq = fifo_ready & ucsrb[UDRIE_BIT];
   assign txc_irq  = txc & ucsrb[TXCIE_BIT];

endmodule

//--- design/usart_tx_shifter.sv
module usart_tx_shifter
   import avr_io_pkg::*;
(
   input  logic     cp2,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  io_data_t in_data,
   input  logic     txen,
   input  io_data_t ubrr,
   output logic     txd,
   output logic     frame_done
);

   localparam int presc_w = $bits(io_data_t) + $clog2(BAUD_OVERSAMPLE);

   logic               busy;
   logic [presc_w-1:0] presc;
   logic [presc_w-1:0] presc_last;
   logic               bit_end;
   logic [3:0]         bit_cnt;
   logic [9:0]         shift_reg;
   logic               accept;

   // Cycles per bit minus one
   assign presc_last = presc_w'((int'(ubrr) + 1) * BAUD_OVERSAMPLE - 1);
   assign bit_end    = busy && (presc == presc_last);

   assign in_ready   = !busy && txen;
   assign accept     = in_valid && in_ready;

   // Last cycle of the stop bit
   assign frame_done = bit_end && (bit_cnt == 4'd9);

   // Line idles high through ones shifted in behind the frame
   assign txd = shift_reg[0];

   always_ff @(posedge cp2 or negedge rst_n) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         presc     <= '0;
         bit_cnt   <= '0;
         shift_reg <= '1;
      end else if (accept) begin
         // Stop, data LSB first, start
         busy      <= 1'b1;
         presc     <= '0;
         bit_cnt   <= '0;
         shift_reg <= {1'b1, in_data, 1'b0};
      end else if (busy) begin
         if (bit_end) begin
            presc     <= '0;
            shift_reg <= {1'b1, shift_reg[9:1]};
            if (bit_cnt == 4'd9) begin
               busy    <= 1'b0;
               bit_cnt <= '0;
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end else begin
            presc <= presc + 1'b1;
         end
      end
   end

endmodule

//--- files.f
design/avr_io_pkg.sv
design/io_bus_if.sv
design/parallel_port.sv
design/usart_tx_regs.sv
design/tx_fifo.sv
design/usart_tx_shifter.sv
design/io_read_mux.sv
design/peripherals.sv
verification/tb_peripherals.sv

//--- verification/tb_peripherals.sv
module tb_peripherals
   import avr_io_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD  = 100;
   localparam int UBRR_VAL    = 0;
   localparam int BIT_CYCLES  = (UBRR_VAL + 1) * BAUD_OVERSAMPLE;
   // Five frames in all, plus margin for the register tests
   localparam int TIMEOUT_CYC = 5 * 10 * BIT_CYCLES + 2000;

   logic        cp2;
   logic        rst_n;
   io_adr_t     adr;
   logic        iore;
   logic        iowe;
   io_data_t    dbus_in;
   io_data_t    dbus_out;
   logic        out_en;
   io_data_t    porta_portx;
   io_data_t    porta_ddrx;
   io_data_t    porta_pinx;
   io_data_t    portb_portx;
   io_data_t    portb_ddrx;
   io_data_t    portb_pinx;
   logic        txd;
   logic        udre_irq;
   logic        txc_irq;
   logic        txc_irq_ack;

   logic [31:0] lcg_state = 32'h2921;
   int          test_errs;
   int          tests_passed;
   int          tests_failed;

   peripherals #(
      .tx_fifo_depth (2)
   ) dut_i (.*);

   initial begin
      cp2 = 1'b0;
      forever #(CLK_PERIOD / 2) cp2 = ~cp2;
   end

   // ==================================================
   // Helpers
   // ==================================================

   function automatic io_data_t rand_byte();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];
   endfunction

   task automatic report_mismatch(input string name, input logic [7:0] exp,
                                  input logic [7:0] act);
      $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
      test_errs++;
   endtask

   task automatic report_error(input string what);
      $display("ERROR %s", what);
      test_errs++;
   endtask

   task automatic finish_test(input string name);
      if (test_errs == 0) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, test_errs);
      end
   endtask

   // Bus tasks start and end on a falling edge
   task automatic io_write(input io_adr_t a, input io_data_t d);
      adr     = a;
      dbus_in = d;
      iowe    = 1'b1;
      @(negedge cp2);
      iowe    = 1'b0;
   endtask

   task automatic io_read(input io_adr_t a, output io_data_t d, output logic en);
      adr  = a;
      iore = 1'b1;
      #(CLK_PERIOD / 4);
      d    = dbus_out;
      en   = out_en;
      @(negedge cp2);
      iore = 1'b0;
   endtask

   task automatic check_read(input string name, input io_data_t exp, input io_data_t d,
                             input logic en);
      if (en !== 1'b1) report_error({"out_en low on read of ", name});
      if (d !== exp) report_mismatch(name, exp, d);
   endtask

   // Waits for the start bit, then samples near the centre of each bit
   task automatic check_frame(input io_data_t exp);
      logic [9:0] frame;
      int         wait_cyc;
      frame    = {1'b1, exp, 1'b0};
      wait_cyc = 0;
      while (txd === 1'b1 && wait_cyc < 4 * BIT_CYCLES) begin
         @(negedge cp2);
         wait_cyc++;
      end
      if (txd !== 1'b0) begin
         report_error("no start bit seen on txd");
      end else begin
         repeat (BIT_CYCLES / 2 - 1) @(negedge cp2);
         for (int i = 0; i < 10; i++) begin
            if (txd !== frame[i]) report_mismatch($sformatf("txd bit %0d", i), frame[i], txd);
            if (i < 9) begin
               repeat (BIT_CYCLES) @(negedge cp2);
            end
         end
      end
   endtask

   // ==================================================
   // Tests
   // ==================================================

   task automatic test_reset();
      test_errs = 0;
      if (txd !== 1'b1) report_mismatch("txd", 8'h01, txd);
      if (udre_irq !== 1'b0) report_mismatch("udre_irq", 8'h00, udre_irq);
      if (txc_irq !== 1'b0) report_mismatch("txc_irq", 8'h00, txc_irq);
      if (porta_portx !== 8'h00) report_mismatch("porta_portx", 8'h00, porta_portx);
      if (porta_ddrx !== 8'h00) report_mismatch("porta_ddrx", 8'h00, porta_ddrx);
      if (portb_portx !== 8'h00) report_mismatch("portb_portx", 8'h00, portb_portx);
      if (portb_ddrx !== 8'h00) report_mismatch("portb_ddrx", 8'h00, portb_ddrx);
      finish_test("reset");
   endtask

   task automatic test_port_regs();
      io_adr_t  adrs [4] = '{PORTA_ADR, DDRA_ADR, PORTB_ADR, DDRB_ADR};
      string    names [4] = '{"PORTA", "DDRA", "PORTB", "DDRB"};
      io_data_t vals [4];
      io_data_t rdata;
      logic     ren;
      test_errs = 0;
      foreach (vals[i]) vals[i] = rand_byte();
      foreach (vals[i]) io_write(adrs[i], vals[i]);
      if (porta_portx !== vals[0]) report_mismatch("porta_portx", vals[0], porta_portx);
      if (porta_ddrx !== vals[1]) report_mismatch("porta_ddrx", vals[1], porta_ddrx);
      if (portb_portx !== vals[2]) report_mismatch("portb_portx", vals[2], portb_portx);
      if (portb_ddrx !== vals[3]) report_mismatch("portb_ddrx", vals[3], portb_ddrx);
      for (int i = 0; i < 4; i++) begin
         io_read(adrs[i], rdata, ren);
         check_read(names[i], vals[i], rdata, ren);
      end
      finish_test("port_regs");
   endtask

   task automatic test_pin_sync();
      io_data_t pa;
      io_data_t pb;
      io_data_t rdata;
      logic     ren;
      test_errs  = 0;
      pa         = rand_byte();
      pb         = rand_byte();
      porta_pinx = pa;
      portb_pinx = pb;
      repeat (3) @(negedge cp2);
      io_read(PINA_ADR, rdata, ren);
      check_read("PINA", pa, rdata, ren);
      io_read(PINB_ADR, rdata, ren);
      check_read("PINB", pb, rdata, ren);
      io_read(6'h00, rdata, ren);
      if (ren !== 1'b0) report_error("out_en high on read of unused address 00");
      finish_test("pin_sync");
   endtask

   task automatic test_single_frame();
      io_data_t b;
      test_errs = 0;
      b         = rand_byte();
      io_write(UBRR_ADR, io_data_t'(UBRR_VAL));
      io_write(UCSRB_ADR, io_data_t'(1 << TXEN_BIT));
      io_write(UDR_ADR, b);
      check_frame(b);
      repeat (BIT_CYCLES / 2 + 2) @(negedge cp2);
      finish_test("single_frame");
   endtask

   task automatic test_back_to_back();
      io_data_t bytes [3];
      io_data_t rdata;
      logic     ren;
      test_errs = 0;
      foreach (bytes[i]) bytes[i] = rand_byte();
      // TXC is still set from the single frame
      io_write(UCSRA_ADR, io_data_t'(1 << TXC_BIT));
      io_write(UCSRB_ADR, io_data_t'((1 << TXEN_BIT) | (1 << UDRIE_BIT) | (1 << TXCIE_BIT)));
      if (txc_irq !== 1'b0) report_mismatch("txc_irq", 8'h00, txc_irq);
      fork
         begin
            foreach (bytes[i]) io_write(UDR_ADR, bytes[i]);
            // One byte in the shifter, two in the FIFO
            @(negedge cp2);
            io_read(UCSRA_ADR, rdata, ren);
            if (rdata[UDRE_BIT] !== 1'b0) report_mismatch("UCSRA.UDRE", 8'h00, rdata[UDRE_BIT]);
            if (udre_irq !== 1'b0) report_mismatch("udre_irq", 8'h00, udre_irq);
         end
         begin
            foreach (bytes[i]) check_frame(bytes[i]);
         end
      join
      repeat (BIT_CYCLES / 2 + 2) @(negedge cp2);
      io_read(UCSRA_ADR, rdata, ren);
      if (rdata[TXC_BIT] !== 1'b1) report_mismatch("UCSRA.TXC", 8'h01, rdata[TXC_BIT]);
      if (txc_irq !== 1'b1) report_mismatch("txc_irq", 8'h01, txc_irq);
      finish_test("back_to_back");
   endtask

   task automatic test_txc_clear();
      io_data_t b;
      io_data_t rdata;
      logic     ren;
      test_errs   = 0;
      txc_irq_ack = 1'b1;
      @(negedge cp2);
      txc_irq_ack = 1'b0;
      if (txc_irq !== 1'b0) report_mismatch("txc_irq", 8'h00, txc_irq);
      io_read(UCSRA_ADR, rdata, ren);
      if (rdata[TXC_BIT] !== 1'b0) report_mismatch("UCSRA.TXC", 8'h00, rdata[TXC_BIT]);
      b = rand_byte();
      io_write(UDR_ADR, b);
      check_frame(b);
      repeat (BIT_CYCLES / 2 + 2) @(negedge cp2);
      if (txc_irq !== 1'b1) report_mismatch("txc_irq", 8'h01, txc_irq);
      // Software clear by writing a one to TXC
      io_write(UCSRA_ADR, io_data_t'(1 << TXC_BIT));
      if (txc_irq !== 1'b0) report_mismatch("txc_irq", 8'h00, txc_irq);
      io_read(UCSRA_ADR, rdata, ren);
      if (rdata[TXC_BIT] !== 1'b0) report_mismatch("UCSRA.TXC", 8'h00, rdata[TXC_BIT]);
      finish_test("txc_clear");
   endtask

   // ==================================================
   // Main sequence and watchdog
   // ==================================================

   initial begin
      rst_n        = 1'b0;
      adr          = '0;
      iore         = 1'b0;
      iowe         = 1'b0;
      dbus_in      = '0;
      porta_pinx   = '0;
      portb_pinx   = '0;
      txc_irq_ack  = 1'b0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (4) @(negedge cp2);
      rst_n = 1'b1;
      @(negedge cp2);
      test_reset();
      test_port_regs();
      test_pin_sync();
      test_single_frame();
      test_back_to_back();
      test_txc_clear();
      $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYC) @(posedge cp2);
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYC);
      $display("=== FAIL ===");
      $finish;
   end

endmodule
